/* project.f */
verilog/vae_sampling_pkg.sv
verilog/sqrt_segment_select.sv
verilog/piecewise_sqrt.sv
verilog/gaussian_prng.sv
verilog/reparam_sampler.sv
verilog/vae_sampling_wb.sv
sim/vae_sampling_checker.sv
sim/vae_sampling_tb.sv

/* Bender.yml */
package:
  name: vae_sampling

sources:
  - files:
      - verilog/vae_sampling_pkg.sv
      - verilog/sqrt_segment_select.sv
      - verilog/piecewise_sqrt.sv
      - verilog/gaussian_prng.sv
      - verilog/reparam_sampler.sv
      - verilog/vae_sampling_wb.sv
  - target: simulation
    files:
      - sim/vae_sampling_checker.sv
      - sim/vae_sampling_tb.sv

/* sim/vae_sampling_tb.sv */
`timescale 1ns/1ps

module vae_sampling_tb;

    localparam int          N_TABLE     = 8;             // Directed entries
    localparam int          N_RANDOM    = 16;            // LFSR-driven entries
    localparam int          ACK_LIMIT   = 16;            // Cycles allowed for one bus ack
    localparam int          POLL_LIMIT  = 20;            // STATUS reads allowed per sample
    localparam logic [31:0] RAND_SEED   = 32'h3c86ff2d;
    localparam logic [31:0] RAND_TAPS   = 32'hB4BCD35C;  // Stimulus LFSR mask
    localparam int          EPS_SCALE   = 1 << vae_sampling_pkg::EPS_SHIFT;
    localparam longint      WATCHDOG_NS = longint'(N_TABLE + N_RANDOM + 8) * 40 * 40;

    typedef struct packed {
        vae_sampling_pkg::sample_req_t req;  // Both lanes' operands
        logic [1:0][3:0]               seg;  // Expected sqrt segment per lane
    } stim_t;

    logic        clk;
    logic        reset;
    logic [5:0]  adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        we;
    logic [3:0]  sel;
    logic        cyc;
    logic        stb;
    logic        ack;

    stim_t       stim_table [N_TABLE];
    logic [31:0] rand_state = RAND_SEED;
    logic [31:0] model_lfsr [vae_sampling_pkg::N_LANES];  // Mirror of each lane's noise LFSR

    vae_sampling_wb u_vae_sampling_wb (
        .clk   (clk),
        .reset (reset),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .we    (we),
        .sel   (sel),
        .cyc   (cyc),
        .stb   (stb),
        .ack   (ack)
    );

    bind vae_sampling_wb vae_sampling_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("Watchdog expired before the test sequence finished");
    end

    // First protocol assertion failure ends the run
    initial begin
        wait (u_vae_sampling_wb.u_checker.assert_errors != 0);
        stop_with_failure("A protocol assertion in the bound checker failed");
    end

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_fixed(string name, vae_sampling_pkg::fixed_t exp_v,
                               vae_sampling_pkg::fixed_t act_v);
        if (act_v !== exp_v) begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, exp_v, act_v);
            stop_with_failure("Fixed-point result mismatch");
        end
    endtask

    task automatic check_word(string name, logic [31:0] exp_v, logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, exp_v, act_v);
            stop_with_failure("Register word mismatch");
        end
    endtask

    function automatic logic [31:0] galois_step(logic [31:0] s, logic [31:0] taps);
        return s[0] ? ((s >> 1) ^ taps) : (s >> 1);  // Taps fold in when a one drops out
    endfunction

    function automatic logic [31:0] next_random(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], rand_state[0]};  // One step per bit taken
            rand_state = galois_step(rand_state, RAND_TAPS);
        end
        return v;
    endfunction

    function automatic vae_sampling_pkg::fixed_t mul_q27(vae_sampling_pkg::fixed_t a,
                                                         vae_sampling_pkg::fixed_t b);
        longint p;
        p = longint'(a) * longint'(b);  // Exact 64-bit product
        p = p >>> vae_sampling_pkg::FRAC_BITS;
        return p[31:0];
    endfunction

    function automatic vae_sampling_pkg::fixed_t wrap_add(vae_sampling_pkg::fixed_t a,
                                                          vae_sampling_pkg::fixed_t b);
        return 32'(longint'(a) + longint'(b));  // Carry out dropped
    endfunction

    function automatic vae_sampling_pkg::fixed_t noise_from_state(logic [31:0] s);
        int acc;
        acc = 0;
        for (int i = 0; i < 4; i++) begin
            acc += int'($signed(s[8*i +: 8]));  // Bytes read as signed
        end
        return acc * EPS_SCALE;
    endfunction

    // Count of breakpoints at or below the value
    function automatic logic [3:0] find_segment(vae_sampling_pkg::fixed_t v);
        logic [3:0] s;
        s = 4'd0;
        for (int i = 0; i < vae_sampling_pkg::N_BREAKS; i++) begin
            if (v >= vae_sampling_pkg::SEG_BREAK[i]) s = 4'(i + 1);
        end
        return s;
    endfunction

    function automatic vae_sampling_pkg::sample_res_t model_sample(
        vae_sampling_pkg::sample_req_t req, logic [1:0][3:0] segs);
        vae_sampling_pkg::sample_res_t res;
        vae_sampling_pkg::fixed_t      root;
        vae_sampling_pkg::fixed_t      eps;
        for (int l = 0; l < vae_sampling_pkg::N_LANES; l++) begin
            root = wrap_add(mul_q27(vae_sampling_pkg::SEG_SLOPE[segs[l]], req.variance[l]),
                            vae_sampling_pkg::SEG_INTERCEPT[segs[l]]);
            eps  = noise_from_state(model_lfsr[l]);  // Pre-step state feeds this sample
            res.sample[l]  = wrap_add(req.mean[l], mul_q27(root, eps));
            res.epsilon[l] = eps;
            model_lfsr[l]  = galois_step(model_lfsr[l], vae_sampling_pkg::PRNG_TAPS);
        end
        return res;
    endfunction

    function automatic stim_t make_stim(vae_sampling_pkg::fixed_t m0, vae_sampling_pkg::fixed_t v0,
                                        vae_sampling_pkg::fixed_t m1, vae_sampling_pkg::fixed_t v1,
                                        logic [3:0] s0, logic [3:0] s1);
        stim_t e;
        e.req.mean     = {m1, m0};
        e.req.variance = {v1, v0};
        e.seg          = {s1, s0};
        return e;
    endfunction

    // Called 2 ns after a rising edge, returns 2 ns after the ack edge
    task automatic wb_cycle(logic [5:0] a, logic w, logic [31:0] d, output logic [31:0] q);
        int waits;
        adr   = a;
        we    = w;
        dat_w = d;
        sel   = 4'hF;
        cyc   = 1'b1;
        stb   = 1'b1;
        waits = 0;
        @(negedge clk);
        while (!ack) begin
            waits++;
            if (waits > ACK_LIMIT) stop_with_failure("Slave never acknowledged a bus cycle");
            @(negedge clk);
        end
        q = dat_r;  // Stable through the ack cycle
        @(posedge clk);
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(logic [5:0] a, logic [31:0] d);
        logic [31:0] unused;
        wb_cycle(a, 1'b1, d, unused);
    endtask

    task automatic wb_read(logic [5:0] a, output logic [31:0] q);
        wb_cycle(a, 1'b0, 32'd0, q);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        polls = 0;
        wb_read(vae_sampling_pkg::STATUS, status);
        while (!status[1]) begin
            polls++;
            if (polls > POLL_LIMIT) stop_with_failure("Done bit never set in STATUS");
            wb_read(vae_sampling_pkg::STATUS, status);
        end
        check_word("STATUS", 32'h2, status);  // Done set, busy clear
    endtask

    task automatic check_results(vae_sampling_pkg::sample_res_t exp_res);
        logic [31:0] rd;
        for (int l = 0; l < vae_sampling_pkg::N_LANES; l++) begin
            wb_read(6'(vae_sampling_pkg::SAMPLE0 + l), rd);
            check_fixed($sformatf("SAMPLE%0d", l), exp_res.sample[l], rd);
            wb_read(6'(vae_sampling_pkg::EPS0 + l), rd);
            check_fixed($sformatf("EPS%0d", l), exp_res.epsilon[l], rd);
        end
    endtask

    task automatic run_sample(vae_sampling_pkg::sample_req_t req, logic [1:0][3:0] segs);
        logic [31:0] status;
        logic [31:0] rd;
        wb_write(vae_sampling_pkg::MEAN0, req.mean[0]);
        wb_write(vae_sampling_pkg::MEAN1, req.mean[1]);
        wb_write(vae_sampling_pkg::VAR0, req.variance[0]);
        wb_write(vae_sampling_pkg::VAR1, req.variance[1]);
        wb_write(vae_sampling_pkg::CTRL, 32'h1);
        wb_read(vae_sampling_pkg::STATUS, status);
        check_word("STATUS after start", 32'h1, status);  // Busy, old done cleared
        wait_done();
        check_results(model_sample(req, segs));
        // Zero variance gives a zero root, so z is the mean itself
        for (int l = 0; l < vae_sampling_pkg::N_LANES; l++) begin
            if (req.variance[l] == 0) begin
                wb_read(6'(vae_sampling_pkg::SAMPLE0 + l), rd);
                check_fixed($sformatf("SAMPLE%0d at zero variance", l), req.mean[l], rd);
            end
        end
    endtask

    // Second start lands while the first is in flight
    task automatic start_while_busy(vae_sampling_pkg::sample_req_t req);
        logic [1:0][3:0] segs;
        segs = {find_segment(req.variance[1]), find_segment(req.variance[0])};
        wb_write(vae_sampling_pkg::CTRL, 32'h1);
        wb_write(vae_sampling_pkg::CTRL, 32'h1);
        wait_done();
        check_results(model_sample(req, segs));  // Exactly one LFSR step taken
    endtask

    initial begin
        logic [31:0]                   rd;
        vae_sampling_pkg::sample_req_t req;
        logic [1:0][3:0]               segs;
        reset = 1'b1;
        adr   = 6'd0;
        dat_w = 32'd0;
        we    = 1'b0;
        sel   = 4'h0;
        cyc   = 1'b0;
        stb   = 1'b0;
        for (int l = 0; l < vae_sampling_pkg::N_LANES; l++) begin
            model_lfsr[l] = vae_sampling_pkg::PRNG_SEEDS[l];
        end
        // Zero variance, every breakpoint, 1.0, negative means
        stim_table[0] = make_stim(32'h0C000000, 32'h00000000, 32'hF4000000, 32'h00000000, 0, 0);
        stim_table[1] = make_stim(32'h00000000, 32'h0012C64A, 32'hFE000000, 32'h00C065DB, 1, 2);
        stim_table[2] = make_stim(32'h01000000, 32'h02EB0AF3, 32'hF8000000, 32'h06E7EBAA, 3, 4);
        stim_table[3] = make_stim(32'h10000000, 32'h0DF8CFA6, 32'hE0000000, 32'h16B93CE1, 5, 6);
        stim_table[4] = make_stim(32'h00400000, 32'h22B30F89, 32'hFFC00000, 32'h31CEE823, 7, 8);
        stim_table[5] = make_stim(32'h08000000, 32'h08000000, 32'hF0000000, 32'h08000000, 4, 4);
        stim_table[6] = make_stim(32'hFC000000, 32'h0012C649, 32'h00000000, 32'h3FFFFFFF, 0, 8);
        stim_table[7] = make_stim(32'h00000001, 32'h00000000, 32'h0C000000, 32'h0012C64A, 0, 1);
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int a = 0; a <= 9; a++) begin
            wb_read(6'(a), rd);
            check_word($sformatf("register %0d after reset", a), 32'd0, rd);
        end
        wb_read(6'd63, rd);
        check_word("unmapped read", 32'd0, rd);
        for (int a = 2; a <= 5; a++) begin
            wb_write(6'(a), 32'h5A5A0000 + a * 32'h0101);  // Pattern carries the address
        end
        wb_write(6'd34, 32'hFFFFFFFF);  // Unknown address, low bits match MEAN0
        for (int a = 2; a <= 5; a++) begin
            wb_read(6'(a), rd);
            check_word($sformatf("operand %0d readback", a), 32'h5A5A0000 + a * 32'h0101, rd);
        end
        wb_read(6'd34, rd);
        check_word("unmapped read after write", 32'd0, rd);
        for (int i = 0; i < N_TABLE; i++) begin
            run_sample(stim_table[i].req, stim_table[i].seg);
        end
        start_while_busy(stim_table[N_TABLE-1].req);
        for (int i = 0; i < N_RANDOM; i++) begin
            for (int l = 0; l < vae_sampling_pkg::N_LANES; l++) begin
                req.mean[l]     = next_random(32);
                req.variance[l] = next_random(30);  // Non-negative, below 8.0
                segs[l]         = find_segment(req.variance[l]);
            end
            run_sample(req, segs);
        end
        if (u_vae_sampling_wb.u_checker.assert_errors != 0) begin
            stop_with_failure("Protocol assertions in the bound checker failed");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* sim/vae_sampling_checker.sv */
`timescale 1ns/1ps

module vae_sampling_checker (
    input logic clk,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic in_valid,   // Start pulse into the sampler
    input logic out_valid,  // Result strobe from the sampler
    input logic busy
);

    int unsigned assert_errors = 0;  // Failure count for the end of run

    ack_needs_req: assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb))
        else begin
            $error("ack raised without cyc and stb");
            assert_errors++;
        end

    ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else begin
            $error("ack held for two cycles");
            assert_errors++;
        end

    // Fixed two-cycle sampler latency, both directions
    result_after_start: assert property (@(posedge clk) disable iff (reset)
                                         in_valid |-> ##2 out_valid)
        else begin
            $error("out_valid missing two cycles after in_valid");
            assert_errors++;
        end

    result_has_start: assert property (@(posedge clk) disable iff (reset)
                                       out_valid |-> $past(in_valid, 2))
        else begin
            $error("out_valid without in_valid two cycles earlier");
            assert_errors++;
        end

    start_when_idle: assert property (@(posedge clk) disable iff (reset)
                                      in_valid |-> !$past(busy))
        else begin
            $error("in_valid issued while busy");
            assert_errors++;
        end

endmodule

/* verilog/vae_sampling_wb.sv */
`timescale 1ns/1ps

module vae_sampling_wb (
    input  logic        clk,
    input  logic        reset,
    input  logic [5:0]  adr,    // Word address
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    input  logic        we,
    input  logic [3:0]  sel,    // Only 4'hF writes take effect
    input  logic        cyc,
    input  logic        stb,
    output logic        ack
);

    vae_sampling_pkg::wb_state_e   wb_state;  // Bus handshake state
    vae_sampling_pkg::reg_addr_e   addr;      // Decoded word address
    vae_sampling_pkg::sample_req_t req_q;     // MEAN and VAR registers
    vae_sampling_pkg::sample_res_t res_q;     // SAMPLE and EPS registers
    vae_sampling_pkg::sample_res_t res;       // Sampler output
    logic [31:0]                   rd_data;   // Read mux
    logic                          wr_en;     // Full-word write on ack
    logic                          start_req; // CTRL bit 0 written
    logic                          in_valid;  // Start pulse to sampler
    logic                          out_valid;
    logic                          busy;
    logic                          done;

    assign addr = vae_sampling_pkg::reg_addr_e'(adr);

    // Request seen in IDLE, ack one clock later for one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_state <= vae_sampling_pkg::IDLE;
        end else begin
            case (wb_state)
                vae_sampling_pkg::IDLE: begin
                    if (cyc && stb) begin
                        wb_state <= vae_sampling_pkg::ACK;
                    end
                end
                vae_sampling_pkg::ACK: wb_state <= vae_sampling_pkg::IDLE;
                default:               wb_state <= vae_sampling_pkg::IDLE;
            endcase
        end
    end

    assign ack   = (wb_state == vae_sampling_pkg::ACK) && cyc && stb;
    assign wr_en = ack && we && (sel == 4'hF);

    always_comb begin
        case (addr)
            vae_sampling_pkg::STATUS:  rd_data = {30'd0, done, busy};
            vae_sampling_pkg::MEAN0:   rd_data = req_q.mean[0];
            vae_sampling_pkg::MEAN1:   rd_data = req_q.mean[1];
            vae_sampling_pkg::VAR0:    rd_data = req_q.variance[0];
            vae_sampling_pkg::VAR1:    rd_data = req_q.variance[1];
            vae_sampling_pkg::SAMPLE0: rd_data = res_q.sample[0];
            vae_sampling_pkg::SAMPLE1: rd_data = res_q.sample[1];
            vae_sampling_pkg::EPS0:    rd_data = res_q.epsilon[0];
            vae_sampling_pkg::EPS1:    rd_data = res_q.epsilon[1];
            default:                   rd_data = 32'd0;  // CTRL and unmapped
        endcase
    end

    // Read data latched with the request, valid through the ack cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            dat_r <= 32'd0;
        end else if (wb_state == vae_sampling_pkg::IDLE && cyc && stb) begin
            dat_r <= rd_data;
        end
    end

    // Operand registers, writes land on the ack edge
    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= '0;
        end else if (wr_en) begin
            case (addr)
                vae_sampling_pkg::MEAN0: req_q.mean[0]     <= dat_w;
                vae_sampling_pkg::MEAN1: req_q.mean[1]     <= dat_w;
                vae_sampling_pkg::VAR0:  req_q.variance[0] <= dat_w;
                vae_sampling_pkg::VAR1:  req_q.variance[1] <= dat_w;
                default: ;  // Unknown or read-only, dropped
            endcase
        end
    end

    assign start_req = wr_en && (addr == vae_sampling_pkg::CTRL) && dat_w[0];

    // Start, busy and done
    always_ff @(posedge clk) begin
        if (reset) begin
            in_valid <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            res_q    <= '0;
        end else begin
            in_valid <= start_req && !busy;  // Start while busy is ignored
            if (start_req && !busy) begin
                busy <= 1'b1;
                done <= 1'b0;   // Cleared by the new start
            end else if (out_valid) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (out_valid) begin
                res_q <= res;  // Capture for readback
            end
        end
    end

    reparam_sampler u_reparam_sampler (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .req       (req_q),
        .out_valid (out_valid),
        .res       (res)
    );

endmodule

/* verilog/reparam_sampler.sv */
`timescale 1ns/1ps

module reparam_sampler (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          in_valid,   // One request per pulse
    input  vae_sampling_pkg::sample_req_t req,
    output logic                          out_valid,  // Two cycles after in_valid
    output vae_sampling_pkg::sample_res_t res
);

    wire vae_sampling_pkg::lane_vec_t root;  // Combinational sqrt per lane
    wire vae_sampling_pkg::lane_vec_t eps;   // Current noise per lane

    vae_sampling_pkg::lane_vec_t root_s1;  // Stage 1 payload
    vae_sampling_pkg::lane_vec_t mean_s1;
    vae_sampling_pkg::lane_vec_t eps_s1;
    logic                        valid_s1;
    logic                        valid_s2;

    for (genvar g = 0; g < vae_sampling_pkg::N_LANES; g++) begin : gen_lane
        piecewise_sqrt u_piecewise_sqrt (
            .variance (req.variance[g]),
            .root     (root[g])
        );

        // Steps on the same edge that captures its epsilon
        gaussian_prng u_gaussian_prng (
            .clk     (clk),
            .reset   (reset),
            .seed    (vae_sampling_pkg::PRNG_SEEDS[g]),  // Own sequence per lane
            .step    (in_valid),
            .epsilon (eps[g])
        );
    end

    // Valid pipe, no stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= in_valid;
            valid_s2 <= valid_s1;
        end
    end

    // Stage 1 holds sqrt, mean and the pre-step epsilon
    always_ff @(posedge clk) begin
        if (reset) begin
            root_s1 <= '0;
            mean_s1 <= '0;
            eps_s1  <= '0;
        end else if (in_valid) begin
            root_s1 <= root;
            mean_s1 <= req.mean;
            eps_s1  <= eps;
        end
    end

    // Stage 2 forms z = mean + root * eps
    always_ff @(posedge clk) begin
        if (reset) begin
            res <= '0;
        end else if (valid_s1) begin
            for (int i = 0; i < vae_sampling_pkg::N_LANES; i++) begin
                res.sample[i]  <= vae_sampling_pkg::fx_add(
                    mean_s1[i], vae_sampling_pkg::fx_mul(root_s1[i], eps_s1[i]));
                res.epsilon[i] <= eps_s1[i];  // Kept for readback
            end
        end
    end

    assign out_valid = valid_s2;

endmodule

/* verilog/gaussian_prng.sv */
`timescale 1ns/1ps

module gaussian_prng (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [31:0]              seed,     // Nonzero start state
    input  logic                     step,     // Advance one position
    output vae_sampling_pkg::fixed_t epsilon   // Noise from current state
);

    logic [31:0] lfsr_q;     // Galois shift register
    logic [31:0] lfsr_next;  // State after one shift

    // Right shift, taps fold in when a one drops out
    always_comb begin
        lfsr_next = lfsr_q >> 1;
        if (lfsr_q[0]) begin
            lfsr_next = lfsr_next ^ vae_sampling_pkg::PRNG_TAPS;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr_q <= seed;  // Seed reload, never all zero
        end else if (step) begin
            lfsr_q <= lfsr_next;
        end
    end

    // Follows the state, so it moves one cycle after step
    assign epsilon = vae_sampling_pkg::eps_from_state(lfsr_q);

endmodule

/* verilog/piecewise_sqrt.sv */
`timescale 1ns/1ps

module piecewise_sqrt (
    input  vae_sampling_pkg::fixed_t variance,  // Non-negative in normal use
    output vae_sampling_pkg::fixed_t root       // Approximate sqrt(variance)
);

    vae_sampling_pkg::segment_t segment;  // Line chosen for this variance
    vae_sampling_pkg::fixed_t   scaled;   // slope * variance

    sqrt_segment_select u_sqrt_segment_select (
        .variance (variance),
        .segment  (segment)
    );

    // y = m * x + c
    assign scaled = vae_sampling_pkg::fx_mul(segment.slope, variance);
    assign root   = vae_sampling_pkg::fx_add(scaled, segment.intercept);

endmodule

/* verilog/sqrt_segment_select.sv */
`timescale 1ns/1ps

module sqrt_segment_select (
    input  vae_sampling_pkg::fixed_t   variance,  // Q5.27 input to the sqrt
    output vae_sampling_pkg::segment_t segment    // Line coefficients for that range
);

    logic [3:0] seg_idx;  // Selected line, 0 to 8

    // Priority search, lowest breakpoint above the value wins
    always_comb begin
        seg_idx = 4'(vae_sampling_pkg::N_BREAKS);  // At or above last break
        for (int i = vae_sampling_pkg::N_BREAKS - 1; i >= 0; i--) begin
            if (variance < vae_sampling_pkg::SEG_BREAK[i]) begin
                seg_idx = 4'(i);  // Signed compare, negatives land in 0
            end
        end
    end

    // Table lookup
    always_comb begin
        segment.slope     = vae_sampling_pkg::SEG_SLOPE[seg_idx];
        segment.intercept = vae_sampling_pkg::SEG_INTERCEPT[seg_idx];
    end

endmodule

/* verilog/vae_sampling_pkg.sv */
package vae_sampling_pkg;

    localparam int FRAC_BITS  = 27;  // Q5.27, 1.0 is 2^27
    localparam int N_LANES    = 2;   // Fixed by the register map
    localparam int N_SEGMENTS = 9;   // Lines in the sqrt approximation
    localparam int N_BREAKS   = 8;   // Boundaries between the lines
    localparam int EPS_SHIFT  = 20;  // Byte sum to Q5.27 scale

    typedef logic signed [31:0] fixed_t;         // Signed Q5.27 word
    typedef fixed_t [N_LANES-1:0] lane_vec_t;    // One word per lane, lane 0 in low bits

    typedef struct packed {
        fixed_t slope;      // m of the selected line
        fixed_t intercept;  // c of the selected line
    } segment_t;

    typedef struct packed {
        lane_vec_t mean;
        lane_vec_t variance;
    } sample_req_t;

    typedef struct packed {
        lane_vec_t sample;   // z = mean + sqrt(var) * eps
        lane_vec_t epsilon;  // Noise used for that sample
    } sample_res_t;

    // Breakpoints, 0.00917 up to 6.226
    localparam fixed_t SEG_BREAK [N_BREAKS] = '{
        32'sh0012C64A, 32'sh00C065DB, 32'sh02EB0AF3, 32'sh06E7EBAA,
        32'sh0DF8CFA6, 32'sh16B93CE1, 32'sh22B30F89, 32'sh31CEE823
    };

    // Slopes, 10.444 down to 0.1878
    localparam fixed_t SEG_SLOPE [N_SEGMENTS] = '{
        32'sh538DF4E0, 32'sh13E35F18, 32'sh08C967D7, 32'sh0537E22B, 32'sh038DF4E6,
        32'sh02A918FC, 32'sh021F85C3, 32'sh01BF5F17, 32'sh0180B335
    };

    // Intercepts, segment 0 passes through the origin
    localparam fixed_t SEG_INTERCEPT [N_SEGMENTS] = '{
        32'sh00000000, 32'sh009569DE, 32'sh01A06665, 32'sh02ED9F69, 32'sh045D4D03,
        32'sh05ED0035, 32'sh0773C694, 32'sh0914D30E, 32'sh0A9B04B8
    };

    localparam logic [31:0] PRNG_TAPS = 32'h80200003;  // Galois feedback mask
    localparam logic [N_LANES-1:0][31:0] PRNG_SEEDS = {
        32'h1357BDF9,  // Lane 1
        32'hACE12468   // Lane 0
    };

    typedef enum logic [5:0] {
        CTRL    = 6'd0,  // Bit 0 starts a sample
        STATUS  = 6'd1,  // Bit 0 busy, bit 1 done
        MEAN0   = 6'd2,
        MEAN1   = 6'd3,
        VAR0    = 6'd4,
        VAR1    = 6'd5,
        SAMPLE0 = 6'd6,
        SAMPLE1 = 6'd7,
        EPS0    = 6'd8,
        EPS1    = 6'd9
    } reg_addr_e;

    typedef enum logic {
        IDLE = 1'b0,
        ACK  = 1'b1
    } wb_state_e;

    // Full signed product, scaled back to Q5.27, low word kept
    function automatic fixed_t fx_mul(fixed_t a, fixed_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return prod[FRAC_BITS +: 32];
    endfunction

    function automatic fixed_t fx_add(fixed_t a, fixed_t b);
        return a + b;  // Wraps on overflow
    endfunction

    // Sum of four signed bytes, roughly Gaussian by CLT
    function automatic fixed_t eps_from_state(logic [31:0] state);
        logic signed [7:0] byte_v;
        fixed_t            sum;
        sum = '0;
        for (int i = 0; i < 4; i++) begin
            byte_v = state[8*i +: 8];
            sum    = sum + byte_v;  // Sign extends to 32 bits
        end
        return sum <<< EPS_SHIFT;
    endfunction

endpackage
